/* Makefile */
VERILATOR ?= verilator
TOP       := snes_cart_loader_tb
FILELIST  := vlog.f
FLAGS     := --binary --timing --assert -Wall
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* apb_loader_front.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_loader_front
	import snes_cart_pkg::*;
(
	input  wire               clk_sys,
	input  wire               RESET,
	input  wire               psel,
	input  wire               penable,
	input  wire               pwrite,
	input  wire  [ADDR_W-1:0] paddr,
	input  wire  [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	input  wire               fill_busy,
	output logic              fill_start,
	output fill_pat_e         fill_pattern,
	output hdr_mode_e         hdr_mode,
	output logic              clear_parse,
	dl_beat_if.source         beat,
	cart_info_if.sink         info
);

	logic              access;
	logic              stall;
	logic              wr_done;
	logic              wr_err;
	logic              ctrl_sel;
	logic              beat_en;
	logic [1:0]        target;
	logic [OFFS_W-1:0] offset;

	region_ovr_e       region_ovr;
	logic              cart_dl;
	logic              cheat_dl;
	logic              pal;

	// ====================
	// APB decode
	// ====================

	assign target = paddr[ADDR_W-1 -: 2];
	assign offset = paddr[OFFS_W-1:0];
	assign access = psel & penable;

	// Cart data must wait until the work RAM clear is over
	assign stall   = access & pwrite & (target == TARGET_CART) & fill_busy;
	assign pready  = ~stall;
	assign wr_done = access & pwrite & ~stall;

	assign ctrl_sel = (target == TARGET_REGS) && (offset == REG_CTRL);

	// Only CTRL is writable in the register region, region 3 is empty
	always_comb begin
		case (target)
			TARGET_CART:  wr_err = 1'b0;
			TARGET_CHEAT: wr_err = 1'b0;
			TARGET_REGS:  wr_err = (offset != REG_CTRL);
			default:      wr_err = 1'b1;
		endcase
	end

	assign pslverr = access & pwrite & wr_err;

	// ====================
	// CTRL
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_mode     <= HDR_AUTO;
			region_ovr   <= REGION_AUTO;
			fill_pattern <= FILL_SNES2;
			cart_dl      <= 1'b0;
			cheat_dl     <= 1'b0;
			fill_start   <= 1'b0;
		end else begin
			// Pulse in the first cycle of a new cart download
			fill_start <= wr_done & ctrl_sel & pwdata[8] & ~cart_dl;
			if (wr_done && ctrl_sel) begin
				hdr_mode     <= hdr_mode_e'(pwdata[2:0]);
				region_ovr   <= region_ovr_e'(pwdata[4:3]);
				fill_pattern <= fill_pat_e'(pwdata[6:5]);
				cart_dl      <= pwdata[8];
				cheat_dl     <= pwdata[9];
			end
		end
	end

	assign clear_parse = fill_start;

	// ====================
	// Stream beats
	// ====================

	assign beat_en = ((target == TARGET_CART) & cart_dl) |
		((target == TARGET_CHEAT) & cheat_dl);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			beat.valid <= 1'b0;
		else
			beat.valid <= wr_done & beat_en;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_done) begin
			beat.target <= target;
			beat.addr   <= offset;
			beat.data   <= pwdata[DATA_W-1:0];
		end
	end

	// Region is frozen while an image is coming in
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_dl) begin
			case (region_ovr)
				REGION_NTSC: pal <= 1'b0;
				REGION_PAL:  pal <= 1'b1;
				default:     pal <= info.region;
			endcase
		end
	end

	// Read mux
	always_comb begin
		prdata = '0;
		if (target == TARGET_REGS) begin
			case (offset)
				REG_CTRL:
					prdata[9:0] = {cheat_dl, cart_dl, 1'b0, fill_pattern, region_ovr, hdr_mode};
				REG_STATUS:
					prdata[13:0] = {fill_busy, pal, info.ram_size, info.rom_type};
				REG_ROM_MASK:
					prdata[MASK_W-1:0] = info.rom_mask;
				REG_RAM_MASK:
					prdata[MASK_W-1:0] = info.ram_mask;
				default:
					prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* cart_header_parse.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_header_parse
	import snes_cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         clear_parse,
	input  hdr_mode_e   hdr_mode,
	dl_beat_if.sink     beat,
	cart_info_if.source info
);

	logic [3:0]        rom_size;
	logic              cart_beat;
	logic              has_base;
	logic [OFFS_W-1:0] size_base;
	logic [OFFS_W-1:0] rom_size_addr;
	logic [OFFS_W-1:0] ram_size_addr;

	assign cart_beat = beat.valid && (beat.target == TARGET_CART);

	// Internal header location for the forced modes
	always_comb begin
		has_base  = 1'b1;
		size_base = '0;
		case (hdr_mode)
			HDR_LOROM:   size_base = 24'h007FD6;
			HDR_HIROM:   size_base = 24'h00FFD6;
			HDR_EXHIROM: size_base = 24'h40FFD6;
			default:     has_base  = 1'b0;
		endcase
	end

	// ROM size byte, RAM size byte two bytes later
	assign rom_size_addr = size_base + HDR_OFFSET;
	assign ram_size_addr = rom_size_addr + 24'd2;

	// ====================
	// Field capture
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size      <= AUTO_ROM_SIZE;
			info.ram_size <= '0;
			info.rom_type <= '0;
			info.region   <= 1'b0;
		end else if (clear_parse) begin
			rom_size      <= AUTO_ROM_SIZE;
			info.ram_size <= '0;
		end else if (cart_beat) begin
			if (beat.addr == '0) begin
				rom_size      <= AUTO_ROM_SIZE;
				info.ram_size <= '0;
				// Loader prepends a size byte in auto mode
				if (hdr_mode == HDR_AUTO && beat.data[7:0] != 8'h00) begin
					info.ram_size <= beat.data[7:4];
					rom_size      <= beat.data[3:0];
				end
				case (hdr_mode)
					HDR_NO_HEADER: info.rom_type <= 8'd0;
					HDR_LOROM:     info.rom_type <= 8'd0;
					HDR_HIROM:     info.rom_type <= 8'd1;
					HDR_EXHIROM:   info.rom_type <= 8'd2;
					default:       info.rom_type <= beat.data[15:8];
				endcase
			end

			if (beat.addr == 24'd2)
				info.region <= beat.data[8];

			if (has_base && beat.addr == rom_size_addr)
				rom_size <= beat.data[11:8];
			if (has_base && beat.addr == ram_size_addr)
				info.ram_size <= beat.data[3:0];
		end
	end

	// ====================
	// Masks
	// ====================

	// Size code n means 1 KiB << n
	assign info.rom_mask = (MASK_W'(1024) << rom_size) - MASK_W'(1);
	assign info.ram_mask = (info.ram_size != 4'd0) ?
		(MASK_W'(1024) << info.ram_size) - MASK_W'(1) : '0;

endmodule

`default_nettype wire

/* cheat_code_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assemble
	import snes_cart_pkg::*;
(
	input  wire        clk_sys,
	input  wire        RESET,
	dl_beat_if.sink    beat,
	output logic       code_valid,
	output cheat_rec_u code_rec
);

	cheat_rec_u rec_q;
	cheat_rec_u rec_next;
	logic       cheat_beat;
	logic       last_word;

	assign cheat_beat = beat.valid && (beat.target == TARGET_CHEAT);

	// Offset 14 is the replace high word
	assign last_word = (beat.addr[3:1] == 3'd7);

	// Pair index from addr[3:2], half from addr[1]
	always_comb begin
		rec_next = rec_q;
		rec_next.words[beat.addr[3:2]][beat.addr[1]] = beat.data;
	end

	// Staging record collects the words
	always_ff @(posedge clk_sys) begin
		if (cheat_beat)
			rec_q <= rec_next;
	end

	// Output copy only moves on a finished record
	always_ff @(posedge clk_sys) begin
		if (cheat_beat && last_word)
			code_rec <= rec_next;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_beat & last_word;
	end

endmodule

`default_nettype wire

/* loader_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One stream write, forwarded a cycle after its APB access
interface dl_beat_if
	import snes_cart_pkg::*;
();
	logic              valid;
	logic [1:0]        target;
	logic [OFFS_W-1:0] addr;
	logic [DATA_W-1:0] data;

	modport source (output valid, target, addr, data);
	modport sink   (input  valid, target, addr, data);
endinterface

// Cartridge properties found in the header
interface cart_info_if
	import snes_cart_pkg::*;
();
	logic [7:0]        rom_type;
	logic [3:0]        ram_size;
	logic [MASK_W-1:0] rom_mask;
	logic [MASK_W-1:0] ram_mask;
	// Raw region bit from the image
	logic              region;

	modport source (output rom_type, ram_size, rom_mask, ram_mask, region);
	modport sink   (input  rom_type, ram_size, rom_mask, ram_mask, region);
endinterface

`default_nettype wire

/* snes_cart_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_cart_loader
	import snes_cart_pkg::*;
#(
	parameter int FILL_ADDR_BITS = 18
) (
	input  wire                       clk_sys,
	input  wire                       RESET,

	// APB slave
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire  [ADDR_W-1:0]         paddr,
	input  wire  [31:0]               pwdata,
	output wire  [31:0]               prdata,
	output wire                       pready,
	output wire                       pslverr,

	// Cheat records
	output wire                       code_valid,
	output wire  [31:0]               code_flags,
	output wire  [31:0]               code_addr,
	output wire  [31:0]               code_compare,
	output wire  [31:0]               code_replace,

	// Work RAM clear
	output wire                       fill_we,
	output wire  [FILL_ADDR_BITS-1:0] fill_addr,
	output wire  [7:0]                fill_data
);

	wire             fill_start;
	wire             fill_busy;
	wire             clear_parse;
	wire fill_pat_e  fill_pattern;
	wire hdr_mode_e  hdr_mode;
	wire cheat_rec_u code_rec;

	dl_beat_if   beat ();
	cart_info_if info ();

	apb_loader_front u_front (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.fill_busy    (fill_busy),
		.fill_start   (fill_start),
		.fill_pattern (fill_pattern),
		.hdr_mode     (hdr_mode),
		.clear_parse  (clear_parse),
		.beat         (beat.source),
		.info         (info.sink)
	);

	cart_header_parse u_header (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.clear_parse (clear_parse),
		.hdr_mode    (hdr_mode),
		.beat        (beat.sink),
		.info        (info.source)
	);

	cheat_code_assemble u_cheat (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.beat       (beat.sink),
		.code_valid (code_valid),
		.code_rec   (code_rec)
	);

	wram_fill_seq #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) u_fill (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.fill_start   (fill_start),
		.fill_pattern (fill_pattern),
		.fill_busy    (fill_busy),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	// Field view of the finished record
	assign code_flags   = code_rec.fields.flags;
	assign code_addr    = code_rec.fields.address;
	assign code_compare = code_rec.fields.compare;
	assign code_replace = code_rec.fields.replace;

endmodule

`default_nettype wire

/* snes_cart_loader_props.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_cart_loader_props #(
	parameter int FILL_ADDR_BITS = 18
) (
	input wire                      clk_sys,
	input wire                      RESET,
	input wire                      psel,
	input wire                      penable,
	input wire [25:0]               paddr,
	input wire                      pready,
	input wire                      fill_busy,
	input wire                      fill_we,
	input wire [FILL_ADDR_BITS-1:0] fill_addr,
	input wire                      code_valid
);

	// A clear only ends after the last address was written
	clear_end: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(fill_busy) |-> ($past(fill_we, 2) && (&$past(fill_addr, 2))))
		else $error("fill_busy fell before the last address");

	// Next write lands on the next address
	addr_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill_we && !(&fill_addr)) |-> ##2
		(fill_we && fill_addr == $past(fill_addr, 2) + 1'b1))
		else $error("fill_addr did not step by one");

	code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid longer than one cycle");

	// A stalled access keeps its address until pready
	stall_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(psel && penable && !pready) |=> (psel && penable && $stable(paddr)))
		else $error("APB access changed while stalled");

endmodule

bind snes_cart_loader snes_cart_loader_props #(
	.FILL_ADDR_BITS (FILL_ADDR_BITS)
) u_props (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.psel       (psel),
	.penable    (penable),
	.paddr      (paddr),
	.pready     (pready),
	.fill_busy  (fill_busy),
	.fill_we    (fill_we),
	.fill_addr  (fill_addr),
	.code_valid (code_valid)
);

`default_nettype wire

/* snes_cart_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_cart_loader_tb
	import snes_cart_pkg::*;
();

	localparam int FILL_BITS  = 10;
	localparam int FILL_WORDS = 1 << FILL_BITS;

	localparam logic [25:0] CART  = 26'h0000000;
	localparam logic [25:0] CHEAT = 26'h1000000;
	localparam logic [25:0] REGS  = 26'h2000000;

	typedef enum {OP_WRITE, OP_READ, OP_WAIT_FILL, OP_WAIT_CODE} op_e;

	typedef struct {
		op_e         op;
		logic [25:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} row_t;

	logic              clk_sys;
	logic              RESET;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [31:0]       pwdata;
	wire  [31:0]       prdata;
	wire               pready;
	wire               pslverr;
	wire               code_valid;
	wire  [31:0]       code_flags;
	wire  [31:0]       code_addr;
	wire  [31:0]       code_compare;
	wire  [31:0]       code_replace;
	wire               fill_we;
	wire  [FILL_BITS-1:0] fill_addr;
	wire  [7:0]        fill_data;

	// Clear in progress, from inside the DUT
	wire               fill_busy = dut.fill_busy;

	row_t        rows[$];
	logic [15:0] cheat_words[8];
	fill_pat_e   exp_pat;
	int          fill_count;
	logic        prev_dl;
	int          cycles;
	int          cycle_limit;
	logic [31:0] lfsr;

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.RESET   (RESET)
	);

	snes_cart_loader #(
		.FILL_ADDR_BITS (FILL_BITS)
	) dut (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.code_valid   (code_valid),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	// ====================
	// Reference rules
	// ====================

	function automatic logic [7:0] pattern_byte(input fill_pat_e pat, input logic [9:0] a);
		case (pat)
			FILL_SNES2:   return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			FILL_SNES1:   return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			FILL_CONST55: return 8'h55;
			default:      return 8'hFF;
		endcase
	endfunction

	// Size code n covers 2^(10+n) bytes, capped at the mask width
	function automatic logic [31:0] rom_mask_of(input logic [3:0] n);
		logic [31:0] m;
		m = '0;
		for (int b = 0; b < MASK_W; b++)
			m[b] = (b < 10 + int'(n));
		return m;
	endfunction

	function automatic logic [31:0] ram_mask_of(input logic [3:0] n);
		return (n == 4'd0) ? 32'd0 : rom_mask_of(n);
	endfunction

	function automatic logic [31:0] status_of(input logic busy, input logic pal,
		input logic [3:0] ram, input logic [7:0] rtype);
		return {18'd0, busy, pal, ram, rtype};
	endfunction

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] lfsr_word();
		logic [15:0] w;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_step(lfsr);
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	// ====================
	// Checks
	// ====================

	task automatic fail_now(input string msg, input logic [127:0] got, input logic [127:0] exp);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
		$display("Test failed");
		$fatal(1, "mismatch");
	endtask

	task automatic check_word(input string msg, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_now(msg, 128'(got), 128'(exp));
	endtask

	task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_now("STATUS {busy,pal,ram_size,rom_type}", 128'(got), 128'(exp));
	endtask

	task automatic check_code(input cheat_rec_u got, input cheat_rec_u exp);
		if (got !== exp)
			fail_now("cheat record fields", got, exp);
	endtask

	// Every clear beat against the pattern rule
	always @(negedge clk_sys) begin
		if (!RESET && fill_we) begin
			check_word("fill_data", 32'(fill_data), 32'(pattern_byte(exp_pat, fill_addr)));
			fill_count++;
			if (fill_count > FILL_WORDS)
				fail_now("fill beat count", 128'(fill_count), 128'(FILL_WORDS));
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("Timeout: the DUT did not respond within %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// ====================
	// APB access
	// ====================

	task automatic apb_xfer(input logic wr, input logic [25:0] a, input logic [31:0] d,
		output logic [31:0] rd, output logic err, output logic busy);
		@(posedge clk_sys);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = a;
		pwdata  = d;
		@(posedge clk_sys);
		#1 penable = 1'b1;
		@(negedge clk_sys);
		while (!pready)
			@(negedge clk_sys);
		rd   = prdata;
		err  = pslverr;
		busy = fill_busy;
		@(posedge clk_sys);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] rd;
		logic        err;
		logic        busy;
		cheat_rec_u  got;
		cheat_rec_u  exp;
		case (r.op)
			OP_WRITE: begin
				if (r.addr == (REGS | 26'(REG_CTRL))) begin
					if (r.data[8] && !prev_dl) begin
						exp_pat    = fill_pat_e'(r.data[6:5]);
						fill_count = 0;
					end
					prev_dl = r.data[8];
				end
				if (r.addr[25:24] == TARGET_CHEAT)
					cheat_words[r.addr[3:1]] = r.data[15:0];
				apb_xfer(1'b1, r.addr, r.data, rd, err, busy);
				check_word("pslverr", 32'(err), r.exp);
				// Cart data only passes once the clear is over
				if (r.addr[25:24] == TARGET_CART) begin
					check_word("fill_busy at cart write", 32'(busy), 32'd0);
					check_word("fill beats before cart write", fill_count, FILL_WORDS);
				end
			end
			OP_READ: begin
				apb_xfer(1'b0, r.addr, 32'd0, rd, err, busy);
				if (r.addr == (REGS | 26'(REG_STATUS)))
					check_status(rd, r.exp);
				else
					check_word("register read", rd, r.exp);
			end
			OP_WAIT_FILL: begin
				@(negedge clk_sys);
				while (fill_busy || fill_count != FILL_WORDS)
					@(negedge clk_sys);
			end
			default: begin
				@(negedge clk_sys);
				while (!code_valid)
					@(negedge clk_sys);
				for (int k = 0; k < 8; k++)
					exp.words[k/2][k%2] = cheat_words[k];
				got.fields.flags   = code_flags;
				got.fields.address = code_addr;
				got.fields.compare = code_compare;
				got.fields.replace = code_replace;
				check_code(got, exp);
			end
		endcase
	endtask

	task automatic add(input op_e op, input logic [25:0] a, input logic [31:0] d,
		input logic [31:0] e);
		row_t r;
		r.op   = op;
		r.addr = a;
		r.data = d;
		r.exp  = e;
		rows.push_back(r);
	endtask

	initial begin
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		exp_pat     = FILL_SNES2;
		fill_count  = 0;
		prev_dl     = 1'b0;
		cycles      = 0;
		cycle_limit = 0;
		lfsr        = 32'hd4e5b84d;

		// CTRL read-back, STATUS is read-only
		add(OP_WRITE, REGS | 26'h0, 32'h4A, 32'd0);
		add(OP_READ,  REGS | 26'h0, 32'd0, 32'h4A);
		add(OP_WRITE, REGS | 26'h4, 32'h1, 32'd1);

		// Snes2 clear with a stalled auto header write
		add(OP_WRITE, REGS | 26'h0, 32'h100, 32'd0);
		add(OP_WRITE, CART | 26'h0, 32'h2153, 32'd0);
		add(OP_WAIT_FILL, 26'd0, 32'd0, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 0, 4'h5, 8'h21));
		add(OP_READ, REGS | 26'h8, 32'd0, rom_mask_of(4'h3));
		add(OP_READ, REGS | 26'hC, 32'd0, ram_mask_of(4'h5));

		// Snes1, zero size byte, then region override
		add(OP_WRITE, REGS | 26'h0, 32'h000, 32'd0);
		add(OP_WRITE, REGS | 26'h0, 32'h120, 32'd0);
		add(OP_WAIT_FILL, 26'd0, 32'd0, 32'd0);
		add(OP_WRITE, CART | 26'h0, 32'h3400, 32'd0);
		add(OP_WRITE, CART | 26'h2, 32'h0100, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 0, 4'h0, 8'h34));
		add(OP_READ, REGS | 26'h8, 32'd0, rom_mask_of(AUTO_ROM_SIZE));
		add(OP_READ, REGS | 26'hC, 32'd0, ram_mask_of(4'h0));
		add(OP_WRITE, REGS | 26'h0, 32'h020, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 1, 4'h0, 8'h34));
		add(OP_WRITE, REGS | 26'h0, 32'h028, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 0, 4'h0, 8'h34));
		add(OP_WRITE, REGS | 26'h0, 32'h030, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 1, 4'h0, 8'h34));

		// Const55 with forced LoROM
		add(OP_WRITE, REGS | 26'h0, 32'h142, 32'd0);
		add(OP_WAIT_FILL, 26'd0, 32'd0, 32'd0);
		add(OP_WRITE, CART | 26'h0, 32'hAAAA, 32'd0);
		add(OP_WRITE, CART | 26'h81D6, 32'h0A00, 32'd0);
		add(OP_WRITE, CART | 26'h81D8, 32'h0003, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 1, 4'h3, 8'h00));
		add(OP_READ, REGS | 26'h8, 32'd0, rom_mask_of(4'hA));
		add(OP_READ, REGS | 26'hC, 32'd0, ram_mask_of(4'h3));

		// ConstFF with forced ExHiROM
		add(OP_WRITE, REGS | 26'h0, 32'h002, 32'd0);
		add(OP_WRITE, REGS | 26'h0, 32'h164, 32'd0);
		add(OP_WAIT_FILL, 26'd0, 32'd0, 32'd0);
		add(OP_WRITE, CART | 26'h0, 32'h0000, 32'd0);
		add(OP_WRITE, CART | 26'h4101D6, 32'h0D00, 32'd0);
		add(OP_WRITE, CART | 26'h4101D8, 32'h0007, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 1, 4'h7, 8'h02));
		add(OP_READ, REGS | 26'h8, 32'd0, rom_mask_of(4'hD));
		add(OP_READ, REGS | 26'hC, 32'd0, ram_mask_of(4'h7));
		add(OP_WRITE, REGS | 26'h0, 32'h00C, 32'd0);
		add(OP_READ, REGS | 26'h4, 32'd0, status_of(0, 0, 4'h7, 8'h02));

		// One cheat record from pseudo-random words
		add(OP_WRITE, REGS | 26'h0, 32'h200, 32'd0);
		for (int k = 0; k < 8; k++)
			add(OP_WRITE, CHEAT | 26'(2 * k), 32'(lfsr_word()), 32'd0);
		add(OP_WAIT_CODE, 26'd0, 32'd0, 32'd0);

		cycle_limit = rows.size() * (2 * FILL_WORDS + 20);

		wait (!RESET);
		foreach (rows[i])
			apply_row(rows[i]);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* snes_cart_pkg.sv */
`default_nettype none

package snes_cart_pkg;

	// ====================
	// Widths
	// ====================

	// APB address, stream word and mask widths
	localparam int ADDR_W = 26;
	localparam int DATA_W = 16;
	localparam int MASK_W = 24;

	// Byte offset field inside one APB region
	localparam int OFFS_W = 24;

	// Copier header in front of the ROM image
	localparam logic [OFFS_W-1:0] HDR_OFFSET = 24'h000200;

	// ROM size code used until the header says otherwise
	localparam logic [3:0] AUTO_ROM_SIZE = 4'hC;

	// ====================
	// Address map
	// ====================

	// Region code in paddr[25:24]
	localparam logic [1:0] TARGET_CART  = 2'd0;
	localparam logic [1:0] TARGET_CHEAT = 2'd1;
	localparam logic [1:0] TARGET_REGS  = 2'd2;

	// Register byte offsets in the register region
	localparam logic [OFFS_W-1:0] REG_CTRL     = 24'h000000;
	localparam logic [OFFS_W-1:0] REG_STATUS   = 24'h000004;
	localparam logic [OFFS_W-1:0] REG_ROM_MASK = 24'h000008;
	localparam logic [OFFS_W-1:0] REG_RAM_MASK = 24'h00000C;

	// ====================
	// Control codes
	// ====================

	typedef enum logic [2:0] {
		HDR_AUTO      = 3'd0,
		HDR_NO_HEADER = 3'd1,
		HDR_LOROM     = 3'd2,
		HDR_HIROM     = 3'd3,
		HDR_EXHIROM   = 3'd4
	} hdr_mode_e;

	// Power-on work RAM contents
	typedef enum logic [1:0] {
		FILL_SNES2   = 2'd0,
		FILL_SNES1   = 2'd1,
		FILL_CONST55 = 2'd2,
		FILL_CONSTFF = 2'd3
	} fill_pat_e;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_ovr_e;

	// Cheat record, seen as stream words or as big endian fields.
	// Stream word k lands in words[k/2][k%2], low halfword first.
	typedef union packed {
		logic [0:3][1:0][DATA_W-1:0] words;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_rec_u;

endpackage

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic RESET
);

	// 125 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		RESET = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1 RESET = 1'b0;
	end

endmodule

`default_nettype wire

/* vlog.f */
snes_cart_pkg.sv
loader_bus_if.sv
apb_loader_front.sv
cart_header_parse.sv
cheat_code_assemble.sv
wram_fill_seq.sv
snes_cart_loader.sv
tb_clock_gen.sv
snes_cart_loader_props.sv
snes_cart_loader_tb.sv

/* wram_fill_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module wram_fill_seq
	import snes_cart_pkg::*;
#(
	parameter int FILL_ADDR_BITS = 18
) (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       fill_start,
	input  fill_pat_e                 fill_pattern,
	output logic                      fill_busy,
	output logic                      fill_we,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data
);

	logic       phase;
	logic       last_addr;
	fill_pat_e  pat_q;
	logic [9:0] pat_addr;

	assign last_addr = &fill_addr;

	// Write on even phase, step address on odd phase
	assign fill_we = fill_busy & ~phase;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fill_busy <= 1'b0;
			phase     <= 1'b0;
			fill_addr <= '0;
			pat_q     <= FILL_SNES2;
		end else if (fill_start) begin
			fill_busy <= 1'b1;
			phase     <= 1'b0;
			fill_addr <= '0;
			pat_q     <= fill_pattern;
		end else if (fill_busy) begin
			phase <= ~phase;
			if (phase) begin
				fill_addr <= fill_addr + 1'b1;
				if (last_addr)
					fill_busy <= 1'b0;
			end
		end
	end

	// Small RAMs see zeros in the upper pattern bits
	assign pat_addr = 10'(fill_addr);

	always_comb begin
		case (pat_q)
			FILL_SNES2:   fill_data = (pat_addr[8] ^ pat_addr[2]) ? 8'h66 : 8'h99;
			FILL_SNES1:   fill_data = (pat_addr[9] ^ pat_addr[0]) ? 8'hFF : 8'h00;
			FILL_CONST55: fill_data = 8'h55;
			default:      fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire
